// ==== source/psgPkg.sv ====
package psgPkg;

    // ========================================
    // voice count and waveform select layout
    // ========================================

    // voice count of the default top level
    localparam int defaultVoices = 3;

    // positions of the select bits inside voiceTypeT
    localparam int selTriangle = 0;
    localparam int selSawtooth = 1;
    localparam int selPulse    = 2;
    localparam int selTable    = 3;
    localparam int selNoise    = 4;
    // sawtooth polarity flip
    localparam int sawInvertBit = 5;

    // ========================================
    // field types
    // ========================================

    typedef logic [11:0] sampleT;       // unsigned waveform sample
    typedef logic [31:0] phaseT;        // accumulator phase
    typedef logic [19:0] freqT;         // increment added every clock
    typedef logic [15:0] pulseWidthT;   // compared against phase[31:20]
    typedef logic [5:0]  voiceTypeT;    // invert flag plus five selects
    typedef logic [3:0]  volumeT;
    // three 12x4 products summed without overflow
    typedef logic [17:0] mixT;

    // per-voice settings, held as levels by the host
    typedef struct packed {
        freqT       freq;
        pulseWidthT pw;
        voiceTypeT  vt;
        volumeT     volume;
        logic       sync;       // hard sync to previous voice
        logic       ringMod;    // xor previous msb into triangle
        logic       fm;         // previous sample adds to pitch
        logic       test;       // hold phase at zero
    } voiceCtrlT;

    typedef voiceCtrlT [defaultVoices-1:0] voiceCtrlArrayT;
    typedef sampleT [defaultVoices-1:0] sampleArrayT;

endpackage

// ==== source/psgPhaseAccumulator.sv ====
`timescale 1ns/1ps

module psgPhaseAccumulator import psgPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  test,
    input  logic  syncEvent,
    input  freqT  freq,
    output phaseT phase
);

    phaseT phaseReg;

    // clear priority
    // rst and test first, then hard sync, then normal stepping
    always_ff @(posedge clk) begin
        if (rst || test) begin
            phaseReg <= '0;
        end else if (syncEvent) begin
            phaseReg <= '0;
        end else begin
            // wraps naturally at 2^32
            phaseReg <= phaseReg + phaseT'(freq);
        end
    end

    assign phase = phaseReg;

endmodule

// ==== source/psgWaveSelect.sv ====
`timescale 1ns/1ps

module psgWaveSelect import psgPkg::*; (
    input  logic [4:0] sel,
    input  sampleT     triangle,
    input  sampleT     sawtooth,
    input  sampleT     pulse,
    input  sampleT     noise,
    input  sampleT     waveTable,
    output sampleT     sample
);

    sampleT combined;

    // waveforms combine by bitwise and
    // start from all ones so every selected wave can only clear bits
    always_comb begin
        combined = '1;
        if (sel[selTriangle]) begin
            combined = combined & triangle;
        end
        if (sel[selSawtooth]) begin
            combined = combined & sawtooth;
        end
        if (sel[selPulse]) begin
            combined = combined & pulse;
        end
        if (sel[selNoise]) begin
            combined = combined & noise;
        end
        if (sel[selTable]) begin
            combined = combined & waveTable;
        end
    end

    // silent voice when nothing is selected
    assign sample = (sel == '0) ? '0 : combined;

endmodule

// ==== source/psgToneGenerator.sv ====
`timescale 1ns/1ps

module psgToneGenerator import psgPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  voiceCtrlT ctrl,
    input  phaseT     prevPhase,
    input  sampleT    prevSample,
    input  sampleT    wave,
    input  logic      ack,
    output phaseT     phase,
    output sampleT    sample
);

    freqT        effFreq;
    logic        prevMsbD;
    logic        syncEvent;
    logic [22:0] noiseReg;
    logic        noiseStep;
    sampleT      tableSample;
    logic        modMsb;
    sampleT      triangleWave;
    sampleT      sawtoothWave;
    sampleT      pulseWave;

    // ========================================
    // pitch and sync
    // ========================================

    // fm adds the previous voice's sample, scaled up by 16, to the pitch
    assign effFreq = ctrl.fm ? ctrl.freq + freqT'({prevSample, 4'h0}) : ctrl.freq;

    // previous msb one cycle late, for rising edge detection
    always_ff @(posedge clk) begin
        if (rst) begin
            prevMsbD <= 1'b0;
        end else begin
            prevMsbD <= prevPhase[31];
        end
    end

    // hard sync on a rising msb of the previous voice
    assign syncEvent = ctrl.sync & prevPhase[31] & ~prevMsbD;

    psgPhaseAccumulator u_phaseAcc (
        .clk       (clk),
        .rst       (rst),
        .test      (ctrl.test),
        .syncEvent (syncEvent),
        .freq      (effFreq),
        .phase     (phase)
    );

    // ========================================
    // noise and wave table
    // ========================================

    // lfsr clocks when phase bits 18 and 22 disagree
    assign noiseStep = phase[18] ^ phase[22];

    // xnor feedback keeps all zeros a legal state
    always_ff @(posedge clk) begin
        if (rst) begin
            noiseReg <= '0;
        end else if (noiseStep) begin
            noiseReg <= {noiseReg[21:0], ~(noiseReg[22] ^ noiseReg[17])};
        end
    end

    // table sample held between acknowledge strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            tableSample <= '0;
        end else if (ack) begin
            tableSample <= wave;
        end
    end

    // ========================================
    // waveform candidates
    // ========================================

    // ring modulation folds the previous msb into the triangle
    assign modMsb       = ctrl.ringMod ? (phase[31] ^ prevPhase[31]) : phase[31];
    assign triangleWave = modMsb ? ~phase[30:19] : phase[30:19];
    assign sawtoothWave = ctrl.vt[sawInvertBit] ? ~phase[31:20] : phase[31:20];
    // high while the top phase bits sit under the width
    assign pulseWave    = {12{pulseWidthT'(phase[31:20]) < ctrl.pw}};

    psgWaveSelect u_waveSelect (
        .sel       (ctrl.vt[4:0]),
        .triangle  (triangleWave),
        .sawtooth  (sawtoothWave),
        .pulse     (pulseWave),
        .noise     (noiseReg[11:0]),
        .waveTable (tableSample),
        .sample    (sample)
    );

endmodule

// ==== source/psgVoiceMixer.sv ====
`timescale 1ns/1ps

module psgVoiceMixer import psgPkg::*; #(
    parameter int numVoices = defaultVoices
) (
    input  logic                      clk,
    input  logic                      rst,
    input  sampleT [numVoices-1:0]    samples,
    input  voiceCtrlT [numVoices-1:0] ctrl,
    output mixT                       mix
);

    mixT products [numVoices];
    mixT sum;
    mixT mixReg;

    // widen both factors first so the product keeps all 16 bits
    always_comb begin
        for (int i = 0; i < numVoices; i++) begin
            products[i] = mixT'(samples[i]) * mixT'(ctrl[i].volume);
        end
    end

    // volume zero drops a voice out of the sum
    always_comb begin
        sum = '0;
        for (int i = 0; i < numVoices; i++) begin
            sum = sum + products[i];
        end
    end

    // one cycle from voice output to mix
    always_ff @(posedge clk) begin
        if (rst) begin
            mixReg <= '0;
        end else begin
            mixReg <= sum;
        end
    end

    assign mix = mixReg;

endmodule

// ==== source/psgCore.sv ====
`timescale 1ns/1ps

module psgCore import psgPkg::*; #(
    parameter int numVoices = defaultVoices
) (
    input  logic                      clk,
    input  logic                      rst,
    input  voiceCtrlT [numVoices-1:0] ctrl,
    input  sampleT [numVoices-1:0]    wave,
    input  logic [numVoices-1:0]      ack,
    output sampleT [numVoices-1:0]    voiceOut,
    output mixT                       mixOut
);

    // phase of every voice, read by its successor in the ring
    phaseT [numVoices-1:0] phases;

    // ========================================
    // voice ring
    // ========================================

    for (genvar i = 0; i < numVoices; i++) begin : voiceGen
        // voice 0 wraps round to the last voice
        localparam int prevIdx = (i + numVoices - 1) % numVoices;

        psgToneGenerator u_toneGen (
            .clk        (clk),
            .rst        (rst),
            .ctrl       (ctrl[i]),
            .prevPhase  (phases[prevIdx]),
            .prevSample (voiceOut[prevIdx]),
            .wave       (wave[i]),
            .ack        (ack[i]),
            .phase      (phases[i]),
            .sample     (voiceOut[i])
        );
    end

    // ========================================
    // output mix
    // ========================================

    psgVoiceMixer #(
        .numVoices (numVoices)
    ) u_voiceMixer (
        .clk     (clk),
        .rst     (rst),
        .samples (voiceOut),
        .ctrl    (ctrl),
        .mix     (mixOut)
    );

endmodule

// ==== test/psgCoreTb.sv ====
`timescale 1ns/1ps

module psgCoreTb import psgPkg::*; ();

    // ========================================
    // run length and random source
    // ========================================

    localparam int tbVoices = defaultVoices;
    localparam int clkPeriod = 20;
    localparam int resetCycles = 8;
    localparam int totalCycles = 20000;
    // watchdog margin on top of the stimulus length
    localparam int watchdogCycles = totalCycles + 500;
    localparam logic [31:0] lfsrSeed = 32'd66985;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] lfsrTaps = 32'h80200003;

    logic                  clk;
    logic                  rst;
    voiceCtrlArrayT        ctrl;
    sampleArrayT           wave;
    logic [tbVoices-1:0]   ack;
    sampleArrayT           voiceOut;
    mixT                   mixOut;

    logic [31:0] lfsrState;

    // model copies of every voice register
    phaseT       mPhase [tbVoices];
    logic        mPrevMsb [tbVoices];
    logic [22:0] mNoise [tbVoices];
    sampleT      mTable [tbVoices];
    sampleT      mOut [tbVoices];
    mixT         mMix;

    psgCore #(
        .numVoices (tbVoices)
    ) u_psgCore (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .wave     (wave),
        .ack      (ack),
        .voiceOut (voiceOut),
        .mixOut   (mixOut)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("error: the test timed out before all stimulus cycles ran");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] result;
        logic        lsb;
        result = '0;
        for (int k = 0; k < n; k++) begin
            lsb = lfsrState[0];
            lfsrState = (lfsrState >> 1) ^ (lsb ? lfsrTaps : 32'h0);
            result = {result[30:0], lsb};
        end
        return result;
    endfunction

    // ========================================
    // reference waveform rules
    // ========================================

    // expected voice sample from model state and current settings
    function automatic sampleT modelSample(input voiceCtrlT c, input phaseT ph,
                                           input phaseT prevPh, input logic [22:0] noise,
                                           input sampleT tbl);
        sampleT triW;
        sampleT sawW;
        sampleT pulseW;
        sampleT res;
        logic   msb;
        msb = c.ringMod ? (ph[31] ^ prevPh[31]) : ph[31];
        triW = msb ? ~ph[30:19] : ph[30:19];
        sawW = c.vt[5] ? ~ph[31:20] : ph[31:20];
        pulseW = ({4'h0, ph[31:20]} < c.pw) ? 12'hfff : 12'h000;
        // selected waves are anded together
        res = 12'hfff;
        if (c.vt[0]) res = res & triW;
        if (c.vt[1]) res = res & sawW;
        if (c.vt[2]) res = res & pulseW;
        if (c.vt[3]) res = res & tbl;
        if (c.vt[4]) res = res & noise[11:0];
        if (c.vt[4:0] == 5'b0) res = '0;
        return res;
    endfunction

    task automatic checkSample(input sampleT got, input sampleT exp, input int voice);
        if (got !== exp) begin
            $display("mismatch at %0t: voice %0d output %h, expected %h", $time, voice, got, exp);
            $display("Test failed");
            $fatal(1, "voice output check failed");
        end
    endtask

    task automatic checkMix(input mixT got, input mixT exp);
        if (got !== exp) begin
            $display("mismatch at %0t: mix output %h, expected %h", $time, got, exp);
            $display("Test failed");
            $fatal(1, "mix output check failed");
        end
    endtask

    // compare outputs, then advance the model by one clock
    task automatic compareAndAdvance();
        phaseT       nPhase [tbVoices];
        logic        nMsb [tbVoices];
        logic [22:0] nNoise [tbVoices];
        sampleT      nTable [tbVoices];
        mixT         sum;
        freqT        eff;
        logic        syncEv;
        int          p;
        for (int i = 0; i < tbVoices; i++) begin
            p = (i + tbVoices - 1) % tbVoices;
            mOut[i] = modelSample(ctrl[i], mPhase[i], mPhase[p], mNoise[i], mTable[i]);
            checkSample(voiceOut[i], mOut[i], i);
        end
        checkMix(mixOut, mMix);
        sum = '0;
        for (int i = 0; i < tbVoices; i++) begin
            p = (i + tbVoices - 1) % tbVoices;
            eff = ctrl[i].fm ? ctrl[i].freq + freqT'({mOut[p], 4'h0}) : ctrl[i].freq;
            syncEv = ctrl[i].sync & mPhase[p][31] & ~mPrevMsb[i];
            nPhase[i] = (rst || ctrl[i].test || syncEv) ? '0 : mPhase[i] + phaseT'(eff);
            nMsb[i] = rst ? 1'b0 : mPhase[p][31];
            nNoise[i] = mNoise[i];
            if (rst) nNoise[i] = '0;
            else if (mPhase[i][18] != mPhase[i][22])
                nNoise[i] = {mNoise[i][21:0], ~(mNoise[i][22] ^ mNoise[i][17])};
            nTable[i] = rst ? '0 : (ack[i] ? wave[i] : mTable[i]);
            sum = sum + mixT'(mOut[i]) * mixT'(ctrl[i].volume);
        end
        for (int i = 0; i < tbVoices; i++) begin
            mPhase[i] = nPhase[i];
            mPrevMsb[i] = nMsb[i];
            mNoise[i] = nNoise[i];
            mTable[i] = nTable[i];
        end
        mMix = rst ? '0 : sum;
    endtask

    // ========================================
    // stimulus
    // ========================================

    // first ten segments walk each single select bit twice, later ones mix them
    task automatic newControls(input int seg);
        voiceCtrlArrayT c;
        for (int i = 0; i < tbVoices; i++) begin
            c[i].freq = freqT'(randomBits(20));
            c[i].pw = pulseWidthT'(randomBits(13));
            c[i].vt[5] = randomBits(1) != 32'd0;
            if (seg < 10) c[i].vt[4:0] = 5'(32'd1 << (seg % 5));
            else c[i].vt[4:0] = 5'(randomBits(5));
            c[i].volume = volumeT'(randomBits(4));
            c[i].sync = randomBits(1) != 32'd0;
            c[i].ringMod = randomBits(1) != 32'd0;
            c[i].fm = randomBits(1) != 32'd0;
            // test clear only now and then
            c[i].test = randomBits(3) == 32'd0;
        end
        ctrl <= c;
    endtask

    initial begin
        int holdLeft;
        int seg;
        lfsrState = lfsrSeed;
        rst = 1'b1;
        ctrl = '0;
        wave = '0;
        ack = '0;
        // model starts from the cleared state of the first reset edge
        for (int i = 0; i < tbVoices; i++) begin
            mPhase[i] = '0;
            mPrevMsb[i] = 1'b0;
            mNoise[i] = '0;
            mTable[i] = '0;
        end
        mMix = '0;
        holdLeft = 0;
        seg = 0;
        for (int cyc = 0; cyc < totalCycles; cyc++) begin
            @(posedge clk);
            rst <= (cyc < resetCycles);
            if (holdLeft == 0) begin
                newControls(seg);
                seg++;
                holdLeft = 64 + int'(randomBits(9) % 32'd449);
            end
            holdLeft--;
            for (int i = 0; i < tbVoices; i++) begin
                wave[i] <= sampleT'(randomBits(12));
                ack[i] <= randomBits(1) != 32'd0;
            end
            // outputs are settled half a period after the edge
            @(negedge clk);
            compareAndAdvance();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== filelist.f ====
source/psgPkg.sv
source/psgPhaseAccumulator.sv
source/psgWaveSelect.sv
source/psgToneGenerator.sv
source/psgVoiceMixer.sv
source/psgCore.sv
test/psgCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the psgCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

# compile the package, RTL and testbench into one binary
verilator --binary --timing -j 0 --top-module psgCoreTb -f filelist.f -o psgCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# run and keep the output for the pass search
output=$(./obj_dir/psgCoreSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1
